// File: sprite_macros.svh
//******************************
// raster, sprite and key constants
//******************************
`ifndef SPRITE_MACROS_SVH
`define SPRITE_MACROS_SVH

// 640x480 horizontal timing, in pixels
`define H_VISIBLE 640
`define H_FRONT 16
`define H_SYNC 96
`define H_TOTAL 800

// vertical timing, in lines
`define V_VISIBLE 480
`define V_FRONT 10
`define V_SYNC 2
`define V_TOTAL 525

`define SPRITE_SIZE 32
`define START_X 304
`define START_Y 224

// keyboard scan codes
`define KEY_DOWN 22
`define KEY_UP 26
`define KEY_LEFT 4
`define KEY_RIGHT 7

`define PHASE_LAST 59
`define PHASE_STEP_A_END 15
`define PHASE_STAND1_END 30
`define PHASE_STEP_B_END 45

`define TRANSPARENT 24'hffffff // white is the sprite color key

`endif

// File: sprite_pkg.sv
//******************************
// shared types of the sprite pipeline
//******************************
package sprite_pkg;

	// screen coordinate, 0..799 fits
	typedef logic [9:0] coord_t;

	// rgb, red in the top byte
	typedef logic [23:0] color_t;

	typedef logic [7:0] channel_t;

	typedef logic [7:0] keycode_t;

	// 0 down, 1 up, 2 left, 3 right
	typedef logic [1:0] dir_t;

	typedef logic [5:0] phase_t;

	// direction * 3 + sub-pose (0 stand, 1 step a, 2 step b)
	typedef logic [3:0] pose_t;

	// {pose, local y, local x}
	typedef logic [13:0] sprite_addr_t;

	// {y, x}
	typedef logic [19:0] bg_addr_t;

	typedef enum logic
	{
		IDLE,
		WALK
	} motion_state_t;

endpackage

// File: pixel_if.sv
//******************************
// raster position and sync flags
//******************************
`timescale 1ns/1ps

interface pixel_if;

	sprite_pkg::coord_t x;
	sprite_pkg::coord_t y;
	logic visible;
	logic hs; // active low
	logic vs; // active low
	logic frame_end; // last cycle of the frame

	modport source (
		output x, y, visible, hs, vs, frame_end
	);

	modport sink (
		input x, y, visible, hs, vs, frame_end
	);

endinterface

// File: vga_timing.sv
//******************************
// vga counters and sync decode
//******************************
`timescale 1ns/1ps
`include "sprite_macros.svh"

module vga_timing (
	input logic CLK,
	input logic reset,
	pixel_if.source raster
);

	localparam sprite_pkg::coord_t H_LAST = sprite_pkg::coord_t'(`H_TOTAL - 1);
	localparam sprite_pkg::coord_t V_LAST = sprite_pkg::coord_t'(`V_TOTAL - 1);
	localparam sprite_pkg::coord_t HS_START = sprite_pkg::coord_t'(`H_VISIBLE + `H_FRONT);
	localparam sprite_pkg::coord_t HS_END = sprite_pkg::coord_t'(`H_VISIBLE + `H_FRONT + `H_SYNC);
	localparam sprite_pkg::coord_t VS_START = sprite_pkg::coord_t'(`V_VISIBLE + `V_FRONT);
	localparam sprite_pkg::coord_t VS_END = sprite_pkg::coord_t'(`V_VISIBLE + `V_FRONT + `V_SYNC);

	sprite_pkg::coord_t h_cnt;
	sprite_pkg::coord_t v_cnt;
	logic line_end;

	assign line_end = (h_cnt == H_LAST);

	always_ff @(posedge CLK)
	begin
		if (reset)
			h_cnt <= '0;
		else if (line_end)
			h_cnt <= '0;
		else
			h_cnt <= h_cnt + 1'b1;
	end

	// steps once per line
	always_ff @(posedge CLK)
	begin
		if (reset)
			v_cnt <= '0;
		else if (line_end)
		begin
			if (v_cnt == V_LAST)
				v_cnt <= '0;
			else
				v_cnt <= v_cnt + 1'b1;
		end
	end

	assign raster.x = h_cnt;
	assign raster.y = v_cnt;

	// decoded from the counters so flags line up with x and y
	assign raster.hs = !((h_cnt >= HS_START) && (h_cnt < HS_END));
	assign raster.vs = !((v_cnt >= VS_START) && (v_cnt < VS_END));
	assign raster.visible = (h_cnt < sprite_pkg::coord_t'(`H_VISIBLE))
		&& (v_cnt < sprite_pkg::coord_t'(`V_VISIBLE));
	assign raster.frame_end = line_end && (v_cnt == V_LAST);

endmodule

// File: player_motion.sv
//******************************
// player walk FSM, position and animation phase
//******************************
`timescale 1ns/1ps
`include "sprite_macros.svh"

module player_motion (
	input logic CLK,
	input logic reset,
	input sprite_pkg::keycode_t keycode,
	input logic frame_end,
	output sprite_pkg::coord_t pos_x,
	output sprite_pkg::coord_t pos_y,
	output sprite_pkg::pose_t pose
);

	localparam sprite_pkg::coord_t X_MAX = sprite_pkg::coord_t'(`H_VISIBLE - `SPRITE_SIZE);
	localparam sprite_pkg::coord_t Y_MAX = sprite_pkg::coord_t'(`V_VISIBLE - `SPRITE_SIZE);
	localparam sprite_pkg::phase_t PHASE_LAST = sprite_pkg::phase_t'(`PHASE_LAST);

	logic key_press;
	sprite_pkg::dir_t key_dir;
	sprite_pkg::dir_t facing;
	sprite_pkg::motion_state_t state;
	sprite_pkg::phase_t phase;
	sprite_pkg::coord_t next_x;
	sprite_pkg::coord_t next_y;
	logic [1:0] sub_pose;

	// scan code decode, unknown codes keep the last direction
	always_ff @(posedge CLK)
	begin
		if (reset)
		begin
			key_press <= 1'b0;
			key_dir <= 2'd0;
		end
		else
		begin
			key_press <= 1'b1;
			case (keycode)
				`KEY_DOWN: key_dir <= 2'd0;
				`KEY_UP: key_dir <= 2'd1;
				`KEY_LEFT: key_dir <= 2'd2;
				`KEY_RIGHT: key_dir <= 2'd3;
				default: key_press <= 1'b0;
			endcase
		end
	end

	// one pixel step, held inside the screen
	always_comb
	begin
		next_x = pos_x;
		next_y = pos_y;
		case (key_dir)
			2'd0:
				if (pos_y < Y_MAX)
					next_y = pos_y + 1'b1;
			2'd1:
				if (pos_y != '0)
					next_y = pos_y - 1'b1;
			2'd2:
				if (pos_x != '0)
					next_x = pos_x - 1'b1;
			default:
				if (pos_x < X_MAX)
					next_x = pos_x + 1'b1;
		endcase
	end

	always_ff @(posedge CLK)
	begin
		if (reset)
		begin
			state <= sprite_pkg::IDLE;
			facing <= 2'd0; // down
			phase <= '0;
			pos_x <= sprite_pkg::coord_t'(`START_X);
			pos_y <= sprite_pkg::coord_t'(`START_Y);
		end
		else if (frame_end)
		begin
			facing <= key_dir;
			if (key_press)
			begin
				state <= sprite_pkg::WALK;
				phase <= (phase == PHASE_LAST) ? '0 : phase + 1'b1;
				pos_x <= next_x;
				pos_y <= next_y;
			end
			else
			begin
				state <= sprite_pkg::IDLE;
				phase <= '0;
			end
		end
	end

	always_comb
	begin
		if (state == sprite_pkg::IDLE)
			sub_pose = 2'd0;
		else if (phase <= sprite_pkg::phase_t'(`PHASE_STEP_A_END))
			sub_pose = 2'd1;
		else if (phase <= sprite_pkg::phase_t'(`PHASE_STAND1_END))
			sub_pose = 2'd0;
		else if (phase <= sprite_pkg::phase_t'(`PHASE_STEP_B_END))
			sub_pose = 2'd2;
		else
			sub_pose = 2'd0;
	end

	assign pose = {2'b00, facing} * 4'd3 + {2'b00, sub_pose};

endmodule

// File: pixel_fetch.sv
//******************************
// sprite hit test and ROM address stage
//******************************
`timescale 1ns/1ps
`include "sprite_macros.svh"

module pixel_fetch (
	input logic CLK,
	input logic reset,
	pixel_if.sink raster_in,
	pixel_if.source raster_out,
	input sprite_pkg::coord_t pos_x,
	input sprite_pkg::coord_t pos_y,
	input sprite_pkg::pose_t pose,
	output logic sprite_hit,
	output sprite_pkg::sprite_addr_t sprite_addr,
	output sprite_pkg::bg_addr_t bg_addr
);

	localparam sprite_pkg::coord_t BOX = sprite_pkg::coord_t'(`SPRITE_SIZE);

	sprite_pkg::coord_t local_x;
	sprite_pkg::coord_t local_y;
	logic in_x;
	logic in_y;

	// offsets into the box, wrap when left of or above it
	assign local_x = raster_in.x - pos_x;
	assign local_y = raster_in.y - pos_y;

	assign in_x = (raster_in.x >= pos_x) && (local_x < BOX);
	assign in_y = (raster_in.y >= pos_y) && (local_y < BOX);

	always_ff @(posedge CLK)
	begin
		if (reset)
			sprite_hit <= 1'b0;
		else
			sprite_hit <= in_x && in_y;
	end

	// 32x32 pose tiles, 1024 words each
	always_ff @(posedge CLK)
	begin
		sprite_addr <= {pose, local_y[4:0], local_x[4:0]};
		bg_addr <= {raster_in.y, raster_in.x}; // 1024 words per line
	end

	// raster follows the addresses by one stage
	always_ff @(posedge CLK)
	begin
		if (reset)
		begin
			raster_out.x <= '0;
			raster_out.y <= '0;
			raster_out.visible <= 1'b0;
			raster_out.hs <= 1'b1;
			raster_out.vs <= 1'b1;
			raster_out.frame_end <= 1'b0;
		end
		else
		begin
			raster_out.x <= raster_in.x;
			raster_out.y <= raster_in.y;
			raster_out.visible <= raster_in.visible;
			raster_out.hs <= raster_in.hs;
			raster_out.vs <= raster_in.vs;
			raster_out.frame_end <= raster_in.frame_end;
		end
	end

endmodule

// File: pixel_mixer.sv
//******************************
// color key compositing and output register
//******************************
`timescale 1ns/1ps
`include "sprite_macros.svh"

module pixel_mixer (
	input logic CLK,
	input logic reset,
	pixel_if.sink raster,
	input logic sprite_hit,
	input sprite_pkg::color_t sprite_color,
	input sprite_pkg::color_t bg_color,
	output sprite_pkg::channel_t red,
	output sprite_pkg::channel_t green,
	output sprite_pkg::channel_t blue,
	output logic hs,
	output logic vs,
	output logic blank
);

	sprite_pkg::color_t pixel;

	always_comb
	begin
		if (!raster.visible)
			pixel = '0; // black in blanking
		else if (sprite_hit && (sprite_color != `TRANSPARENT))
			pixel = sprite_color;
		else
			pixel = bg_color;
	end

	always_ff @(posedge CLK)
	begin
		if (reset)
		begin
			red <= '0;
			green <= '0;
			blue <= '0;
			hs <= 1'b1;
			vs <= 1'b1;
			blank <= 1'b0;
		end
		else
		begin
			red <= pixel[23:16];
			green <= pixel[15:8];
			blue <= pixel[7:0];
			hs <= raster.hs;
			vs <= raster.vs;
			blank <= raster.visible; // low while blanked
		end
	end

endmodule

// File: sprite_top.sv
//******************************
// walking sprite over background, vga out
//******************************
`timescale 1ns/1ps

module sprite_top (
	input logic CLK,
	input logic reset,
	input sprite_pkg::keycode_t keycode,
	output sprite_pkg::sprite_addr_t sprite_addr,
	input sprite_pkg::color_t sprite_color,
	output sprite_pkg::bg_addr_t bg_addr,
	input sprite_pkg::color_t bg_color,
	output sprite_pkg::channel_t red,
	output sprite_pkg::channel_t green,
	output sprite_pkg::channel_t blue,
	output logic hs,
	output logic vs,
	output logic blank
);

	pixel_if raster_now ();
	pixel_if raster_d1 (); // aligned with the ROM data

	sprite_pkg::coord_t pos_x;
	sprite_pkg::coord_t pos_y;
	sprite_pkg::pose_t pose;
	logic sprite_hit;

	vga_timing vga_timing_inst (
		.CLK(CLK),
		.reset(reset),
		.raster(raster_now)
	);

	// position updates land at the next (0, 0)
	player_motion player_motion_inst (
		.CLK(CLK),
		.reset(reset),
		.keycode(keycode),
		.frame_end(raster_now.frame_end),
		.pos_x(pos_x),
		.pos_y(pos_y),
		.pose(pose)
	);

	pixel_fetch pixel_fetch_inst (
		.CLK(CLK),
		.reset(reset),
		.raster_in(raster_now),
		.raster_out(raster_d1),
		.pos_x(pos_x),
		.pos_y(pos_y),
		.pose(pose),
		.sprite_hit(sprite_hit),
		.sprite_addr(sprite_addr),
		.bg_addr(bg_addr)
	);

	pixel_mixer pixel_mixer_inst (
		.CLK(CLK),
		.reset(reset),
		.raster(raster_d1),
		.sprite_hit(sprite_hit),
		.sprite_color(sprite_color),
		.bg_color(bg_color),
		.red(red),
		.green(green),
		.blue(blue),
		.hs(hs),
		.vs(vs),
		.blank(blank)
	);

endmodule

// File: tb_sprite_top.sv
//******************************
// testbench for the walking sprite
// pipeline, hashed ROMs and a model
//******************************
`timescale 1ns/1ps
`include "sprite_macros.svh"

module tb_sprite_top;

	localparam int CLK_PERIOD = 4;
	localparam int NUM_FRAMES = 8;
	localparam int FRAME_CYCLES = `H_TOTAL * `V_TOTAL;
	localparam int TIMEOUT_NS = (NUM_FRAMES + 2) * FRAME_CYCLES * CLK_PERIOD;
	localparam int HS_START = `H_VISIBLE + `H_FRONT;
	localparam int VS_START = `V_VISIBLE + `V_FRONT;
	localparam sprite_pkg::keycode_t KEY_UNKNOWN = 8'h2c;

	logic CLK;
	logic reset;
	sprite_pkg::keycode_t keycode;
	sprite_pkg::sprite_addr_t sprite_addr;
	sprite_pkg::color_t sprite_color;
	sprite_pkg::bg_addr_t bg_addr;
	sprite_pkg::color_t bg_color;
	sprite_pkg::channel_t red, green, blue;
	logic hs, vs, blank;

	// player model, stepped once per frame
	logic m_walk;
	int m_dir;
	int m_phase;
	int m_x;
	int m_y;

	logic [31:0] rng;
	sprite_pkg::keycode_t key_sched [NUM_FRAMES];
	sprite_pkg::keycode_t key_choice [5];

	sprite_top sprite_top_inst (
		.CLK(CLK),
		.reset(reset),
		.keycode(keycode),
		.sprite_addr(sprite_addr),
		.sprite_color(sprite_color),
		.bg_addr(bg_addr),
		.bg_color(bg_color),
		.red(red),
		.green(green),
		.blue(blue),
		.hs(hs),
		.vs(vs),
		.blank(blank)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] r;
		r = s ^ (s << 13);
		r = r ^ (r >> 17);
		r = r ^ (r << 5);
		return r;
	endfunction

	// every address bit reaches every output bit
	function automatic logic [31:0] hash_address(input logic [31:0] addr, input logic [31:0] salt);
		logic [31:0] h;
		h = (addr ^ salt) * 32'h9e3779b1;
		h = xorshift32(h ^ (h >> 15));
		return h ^ (h >> 11);
	endfunction

	function automatic sprite_pkg::color_t sprite_word(input sprite_pkg::sprite_addr_t addr);
		logic [31:0] h;
		h = hash_address({18'd0, addr}, 32'h5bd1e995);
		if (h[31:30] == 2'b00)
			return `TRANSPARENT; // about one pixel in four
		return h[23:0];
	endfunction

	function automatic sprite_pkg::color_t background_word(input sprite_pkg::bg_addr_t addr);
		logic [31:0] h;
		h = hash_address({12'd0, addr}, 32'hc2b2ae35);
		return h[23:0];
	endfunction

	// both ROMs answer in the same cycle
	assign sprite_color = sprite_word(sprite_addr);
	assign bg_color = background_word(bg_addr);

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected)
		begin
			$display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, expected);
			$display("Test failures found");
			$fatal(1);
		end
	endtask

	task automatic advance_model(input sprite_pkg::keycode_t key);
		logic pressed;
		pressed = (key == `KEY_DOWN) || (key == `KEY_UP) || (key == `KEY_LEFT)
			|| (key == `KEY_RIGHT);
		if (key == `KEY_DOWN)
			m_dir = 0;
		else if (key == `KEY_UP)
			m_dir = 1;
		else if (key == `KEY_LEFT)
			m_dir = 2;
		else if (key == `KEY_RIGHT)
			m_dir = 3;
		m_walk = pressed;
		if (!pressed)
			m_phase = 0;
		else
		begin
			m_phase = (m_phase == `PHASE_LAST) ? 0 : m_phase + 1;
			if (m_dir == 0 && m_y < `V_VISIBLE - `SPRITE_SIZE)
				m_y++;
			else if (m_dir == 1 && m_y > 0)
				m_y--;
			else if (m_dir == 2 && m_x > 0)
				m_x--;
			else if (m_dir == 3 && m_x < `H_VISIBLE - `SPRITE_SIZE)
				m_x++;
		end
	endtask

	function automatic sprite_pkg::color_t expected_pixel(input int px, input int py);
		int lx;
		int ly;
		int sub;
		sprite_pkg::color_t spr;
		sprite_pkg::color_t bg;
		lx = px - m_x;
		ly = py - m_y;
		bg = background_word(sprite_pkg::bg_addr_t'(py * 1024 + px));
		if (lx < 0 || ly < 0 || lx >= `SPRITE_SIZE || ly >= `SPRITE_SIZE)
			return bg;
		// step a, stand, step b, stand over one walk cycle
		if (!m_walk || (m_phase > `PHASE_STEP_A_END && m_phase <= `PHASE_STAND1_END)
			|| m_phase > `PHASE_STEP_B_END)
			sub = 0;
		else if (m_phase <= `PHASE_STEP_A_END)
			sub = 1;
		else
			sub = 2;
		spr = sprite_word(sprite_pkg::sprite_addr_t'((m_dir * 3 + sub) * 1024
			+ ly * 32 + lx));
		if (spr == `TRANSPARENT)
			return bg;
		return spr;
	endfunction

	initial
	begin
		CLK = 1'b0;
		forever #(CLK_PERIOD / 2) CLK = ~CLK;
	end

	// key schedule, one code per frame
	initial
	begin
		rng = 32'd74;
		reset = 1'b1;
		keycode = KEY_UNKNOWN;
		key_choice = '{`KEY_DOWN, `KEY_UP, `KEY_LEFT, `KEY_RIGHT, KEY_UNKNOWN};
		key_sched[0] = KEY_UNKNOWN; // idle at the start position first
		for (int i = 1; i < NUM_FRAMES; i++)
		begin
			rng = xorshift32(rng);
			key_sched[i] = key_choice[(i == 1) ? rng % 4 : rng % 5];
		end
		key_sched[NUM_FRAMES - 2] = KEY_UNKNOWN; // stop after walking
		repeat (8) @(posedge CLK);
		reset <= 1'b0;
		for (int f = 0; f < NUM_FRAMES; f++)
		begin
			@(negedge CLK);
			while (vs !== 1'b0)
				@(negedge CLK);
			@(posedge CLK);
			keycode <= key_sched[f];
			while (vs !== 1'b1)
				@(negedge CLK);
		end
	end

	initial
	begin
		int cyc;
		int hs_fall;
		int vs_fall;
		int tx;
		int ty;
		int frames_started;
		logic prev_hs;
		logic prev_vs;
		logic synced;
		logic on_screen;
		sprite_pkg::color_t want;
		cyc = 0;
		hs_fall = -1;
		vs_fall = -1;
		tx = 0;
		ty = 0;
		frames_started = 0;
		prev_hs = 1'b1;
		prev_vs = 1'b1;
		synced = 1'b0;
		m_walk = 1'b0;
		m_dir = 0;
		m_phase = 0;
		m_x = `START_X;
		m_y = `START_Y;
		@(negedge CLK);
		while (reset)
			@(negedge CLK);
		while (frames_started <= NUM_FRAMES)
		begin
			if (prev_hs && !hs)
			begin
				if (hs_fall >= 0)
					check_value("hs period", cyc - hs_fall, `H_TOTAL);
				hs_fall = cyc;
			end
			if (!prev_hs && hs && hs_fall >= 0)
				check_value("hs low width", cyc - hs_fall, `H_SYNC);
			if (!prev_vs && vs && vs_fall >= 0)
				check_value("vs low width", cyc - vs_fall, `V_SYNC * `H_TOTAL);
			// vs falls on the first pixel of line 490
			if (prev_vs && !vs)
			begin
				if (vs_fall >= 0)
					check_value("vs period", cyc - vs_fall, FRAME_CYCLES);
				vs_fall = cyc;
				tx = 0;
				ty = VS_START;
				synced = 1'b1;
			end
			else if (tx == `H_TOTAL - 1)
			begin
				tx = 0;
				ty = (ty == `V_TOTAL - 1) ? 0 : ty + 1;
			end
			else
				tx++;
			if (synced && tx == 0 && ty == 0)
			begin
				frames_started++;
				if (frames_started <= NUM_FRAMES)
					advance_model(keycode); // key held over the last frame end
			end
			if (synced && frames_started <= NUM_FRAMES)
			begin
				on_screen = (tx < `H_VISIBLE) && (ty < `V_VISIBLE);
				want = on_screen ? expected_pixel(tx, ty) : '0;
				check_value("hs", hs, !(tx >= HS_START && tx < HS_START + `H_SYNC));
				check_value("vs", vs, !(ty >= VS_START && ty < VS_START + `V_SYNC));
				check_value("blank", blank, on_screen);
				check_value("rgb", {red, green, blue}, want);
			end
			prev_hs = hs;
			prev_vs = vs;
			cyc++;
			@(negedge CLK);
		end
		$display("All tests passed!");
		$finish;
	end

	initial
	begin
		#(TIMEOUT_NS);
		$display("Timeout: the run did not finish within %0d frame times", NUM_FRAMES + 2);
		$display("Test failures found");
		$fatal(1);
	end

endmodule

// File: sim.f
+incdir+.
sprite_pkg.sv
pixel_if.sv
vga_timing.sv
player_motion.sv
pixel_fetch.sv
pixel_mixer.sv
sprite_top.sv
tb_sprite_top.sv
